// File: flist.f
verilog/core_cfg_pkg.sv
verilog/expipe_pkg.sv
verilog/modn_counter.sv
verilog/rob.sv
verilog/dispatch_unit.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/cdb_arbiter.sv
verilog/ooo_backend_top.sv
tb/tb_ooo_backend.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the out-of-order back end testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert --top-module tb_ooo_backend -f flist.f > "$LOG" 2>&1 ||
    { echo "Verilator build failed, see $LOG"; exit 1; }
./obj_dir/Vtb_ooo_backend >> "$LOG" 2>&1
grep -q '\*\* FAIL \*\*' "$LOG" && { echo "Simulation FAILED, see $LOG"; exit 1; }
grep -q '\*\* PASS \*\*' "$LOG" || { echo "Simulation did not finish, see $LOG"; exit 1; }
echo "Simulation passed"
exit 0

// File: tb/tb_ooo_backend.sv
// Testbench for the out-of-order back end
// Random instruction stream, reference model and in-order commit scoreboard
`timescale 1ns/10ps
`default_nettype none

module tb_ooo_backend import core_cfg_pkg::*; import expipe_pkg::*; #(
    parameter int ROB_DEPTH = 8
) ();

    localparam int IDX_W      = $clog2(ROB_DEPTH);
    localparam int N_INSTR    = 300;
    localparam int FLUSH_AT   = 150;                // Flush after this many issues
    localparam int MAX_CYCLES = N_INSTR * (MUL_ITERS + 2 * ROB_DEPTH) + 2000;

    typedef struct packed {
        op_e                    op;
        logic [XLEN-1:0]        a;
        logic [XLEN-1:0]        b;
        logic [REG_IDX_LEN-1:0] rd;
        logic [IDX_W-1:0]       tag;
    } issued_t;

    logic                   clk_i, rst_n_i, flush_i;
    logic                   issue_valid_i, issue_ready_o;
    op_e                    issue_op_i;
    logic [REG_IDX_LEN-1:0] issue_rd_i;
    logic [XLEN-1:0]        issue_a_i, issue_b_i;
    logic [IDX_W-1:0]       issue_tag_o;
    logic                   comm_ready_i, comm_valid_o, comm_except_o;
    logic [REG_IDX_LEN-1:0] comm_rd_o;
    logic [XLEN-1:0]        comm_value_o;
    except_e                comm_except_code_o;
    logic [IDX_W-1:0]       comm_tag_o;

    issued_t          exp_q[$];                     // Issued but not yet committed
    logic [31:0]      rng_state = 32'd84815;
    logic [IDX_W-1:0] next_tag  = '0;               // Tail index the next issue must get
    int               cycle_cnt = 0;
    int               ready_hold = 0;

    ooo_backend_top #(.ROB_DEPTH(ROB_DEPTH)) u_dut (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i),
        .issue_valid_i (issue_valid_i), .issue_ready_o (issue_ready_o),
        .issue_op_i (issue_op_i), .issue_rd_i (issue_rd_i),
        .issue_a_i (issue_a_i), .issue_b_i (issue_b_i), .issue_tag_o (issue_tag_o),
        .comm_ready_i (comm_ready_i), .comm_valid_o (comm_valid_o),
        .comm_rd_o (comm_rd_o), .comm_value_o (comm_value_o),
        .comm_except_o (comm_except_o), .comm_except_code_o (comm_except_code_o),
        .comm_tag_o (comm_tag_o)
    );

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;                      // 20 ns period

    task automatic stop_on_error();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first failed check");
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Expected commit fields from the ISA rules
    function automatic void ref_result(input op_e op, input logic [XLEN-1:0] a,
                                       input logic [XLEN-1:0] b, output logic [XLEN-1:0] val,
                                       output logic exc, output except_e code);
        logic signed [XLEN:0] wide;                 // One guard bit for signed overflow
        logic [2*XLEN-1:0]    prod;
        val  = a;
        exc  = 1'b0;
        code = EXC_NONE;
        case (op)
            OP_ADD, OP_SUB: begin
                if (op == OP_ADD) wide = $signed({a[XLEN-1], a}) + $signed({b[XLEN-1], b});
                else              wide = $signed({a[XLEN-1], a}) - $signed({b[XLEN-1], b});
                val = wide[XLEN-1:0];               // Wrapped result
                exc = (wide[XLEN] != wide[XLEN-1]);
                if (exc) code = EXC_OVERFLOW;
            end
            OP_XOR: val = a ^ b;
            OP_MUL: begin
                prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
                val  = prod[XLEN-1:0];              // Low half only
            end
            OP_LDI: val = a;
            default: begin                          // Illegal op carries a as its aux value
                exc  = 1'b1;
                code = EXC_ILLEGAL;
            end
        endcase
    endfunction

    task automatic check_field(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        assert (got == exp) else begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // Directed corner cases first and random ops after
    task automatic drive_instr(input int idx);
        logic [31:0] r;
        int          sel;
        r   = next_rand();
        sel = (idx < 6) ? idx : int'(r[31:16]) % 6;
        issue_valid_i = 1'b1;
        issue_rd_i    = r[REG_IDX_LEN-1:0];
        issue_a_i     = next_rand();
        issue_b_i     = next_rand();
        case (sel)
            0:       issue_op_i = OP_LDI;
            1:       issue_op_i = OP_ADD;
            2:       issue_op_i = OP_SUB;
            3:       issue_op_i = OP_ILL;
            4:       issue_op_i = OP_MUL;
            default: issue_op_i = OP_XOR;
        endcase
        if (idx == 1 || (idx >= 6 && r[7:5] == 3'd0)) begin
            issue_a_i = 32'h7fff_ffff;              // Max positive plus 1 overflows on ADD
            issue_b_i = 32'h0000_0001;
        end else if (idx == 2) begin
            issue_a_i = 32'h8000_0000;              // Min negative minus 1
            issue_b_i = 32'h0000_0001;
        end
    endtask

    // Random high and low stretches on the commit side
    task automatic update_comm_ready();
        logic [31:0] r;
        if (ready_hold > 0) begin
            ready_hold--;
        end else begin
            r = next_rand();
            comm_ready_i = (r[1:0] != 2'd0);
            ready_hold   = comm_ready_i ? int'(r[7:4]) : int'(r[9:4]);
        end
    endtask

    initial begin : driver
        int   issued;
        int   flush_wait;
        logic accepted;
        issued        = 0;
        flush_wait    = 0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_op_i    = OP_ADD;
        issue_rd_i    = '0;
        issue_a_i     = '0;
        issue_b_i     = '0;
        comm_ready_i  = 1'b0;
        repeat (3) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        assert (!comm_valid_o && issue_ready_o && issue_tag_o == '0) else begin
            $display("Reset state wrong: commit valid, issue not ready or tag not zero");
            stop_on_error();
        end
        @(posedge clk_i);
        #2;
        comm_ready_i = 1'b1;
        drive_instr(0);
        while (issued < N_INSTR) begin
            @(negedge clk_i);
            accepted = issue_valid_i && issue_ready_o;  // Transfer at the coming edge
            @(posedge clk_i);
            #2;
            flush_i = 1'b0;
            if (accepted) begin
                issued++;
                if (issued == FLUSH_AT) flush_wait = 40;    // Let the ROB fill first
                if (issued < N_INSTR) drive_instr(issued);
                else issue_valid_i = 1'b0;
            end
            if (flush_wait > 0) begin
                comm_ready_i = 1'b0;
                flush_wait--;
                flush_i = (flush_wait == 0);
            end else begin
                update_comm_ready();
            end
        end
        comm_ready_i = 1'b1;                        // Drain
        while (exp_q.size() != 0) @(posedge clk_i);
        repeat (5) @(posedge clk_i);                // A duplicate commit would show here
        $display("** PASS **");
        $finish;
    end

    // Checks every transfer at the falling edge
    always @(negedge clk_i) begin : scoreboard
        issued_t         head, item;
        logic [XLEN-1:0] exp_val;
        logic            exp_exc;
        except_e         exp_code;
        if (rst_n_i) begin
            assert (exp_q.size() <= ROB_DEPTH) else begin
                $display("More instructions in flight than the ROB can hold");
                stop_on_error();
            end
            if (exp_q.size() == ROB_DEPTH) begin
                assert (!issue_ready_o) else begin
                    $display("Issue accepted while all ROB entries are in use");
                    stop_on_error();
                end
            end
            if (flush_i) begin
                assert (!issue_ready_o) else begin
                    $display("Issue ready during the flush cycle");
                    stop_on_error();
                end
                exp_q.delete();                     // Nothing older may commit
                next_tag = '0;
            end else begin
                if (comm_valid_o && comm_ready_i) begin
                    assert (exp_q.size() != 0) else begin
                        $display("Commit seen with no instruction outstanding");
                        stop_on_error();
                    end
                    head = exp_q.pop_front();
                    ref_result(head.op, head.a, head.b, exp_val, exp_exc, exp_code);
                    check_field("comm_tag_o", XLEN'(comm_tag_o), XLEN'(head.tag));
                    check_field("comm_rd_o", XLEN'(comm_rd_o), XLEN'(head.rd));
                    check_field("comm_value_o", comm_value_o, exp_val);
                    check_field("comm_except_o", XLEN'(comm_except_o), XLEN'(exp_exc));
                    check_field("comm_except_code_o", XLEN'(comm_except_code_o),
                                XLEN'(exp_code));
                end
                if (issue_valid_i && issue_ready_o) begin
                    check_field("issue_tag_o", XLEN'(issue_tag_o), XLEN'(next_tag));
                    item.op  = issue_op_i;
                    item.a   = issue_a_i;
                    item.b   = issue_b_i;
                    item.rd  = issue_rd_i;
                    item.tag = next_tag;
                    exp_q.push_back(item);
                    next_tag = next_tag + 1'b1;     // Wraps with the ROB tail
                end
            end
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

// File: verilog/alu_unit.sv
// Single-cycle ALU
// ADD, SUB, XOR with signed overflow detect, result held until CDB grant
`timescale 1ns/10ps
`default_nettype none

module alu_unit import core_cfg_pkg::*; import expipe_pkg::*; #(
    parameter  int ROB_DEPTH   = 8,
    localparam int ROB_IDX_LEN = $clog2(ROB_DEPTH)
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   valid_i,
    output logic                   ready_o,
    input  op_e                    op_i,
    input  logic [XLEN-1:0]        a_i,
    input  logic [XLEN-1:0]        b_i,
    input  logic [ROB_IDX_LEN-1:0] tag_i,
    input  logic                   gnt_i,
    output logic                   req_o,
    output logic [ROB_IDX_LEN-1:0] tag_o,
    output logic [XLEN-1:0]        value_o,
    output logic                   except_o,
    output except_e                except_code_o
);

    logic [XLEN-1:0] res;
    logic            ovf;

    always_comb begin
        res = a_i ^ b_i;
        ovf = 1'b0;
        case (op_i)
            OP_ADD: begin
                res = a_i + b_i;
                ovf = (a_i[XLEN-1] == b_i[XLEN-1]) && (res[XLEN-1] != a_i[XLEN-1]);
            end
            OP_SUB: begin
                res = a_i - b_i;
                ovf = (a_i[XLEN-1] != b_i[XLEN-1]) && (res[XLEN-1] != a_i[XLEN-1]);
            end
            default: ;                              // XOR never overflows
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_o <= 1'b0;
        end else if (flush_i) begin
            req_o <= 1'b0;                          // Abort pending result
        end else if (valid_i && ready_o) begin
            req_o <= 1'b1;
        end else if (gnt_i) begin
            req_o <= 1'b0;                          // Result taken by the CDB
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            tag_o         <= tag_i;
            value_o       <= res;                   // Wrapped result even on overflow
            except_o      <= ovf;
            except_code_o <= ovf ? EXC_OVERFLOW : EXC_NONE;
        end
    end

    assign ready_o = !req_o;                        // Busy until granted

endmodule

`default_nettype wire

// File: verilog/cdb_arbiter.sv
// CDB arbiter
// Round-robin grant between ALU and multiplier, drives the common data bus
`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter import core_cfg_pkg::*; import expipe_pkg::*; #(
    parameter  int ROB_DEPTH   = 8,
    localparam int ROB_IDX_LEN = $clog2(ROB_DEPTH)
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   alu_req_i,
    input  logic [ROB_IDX_LEN-1:0] alu_tag_i,
    input  logic [XLEN-1:0]        alu_value_i,
    input  logic                   alu_except_i,
    input  except_e                alu_except_code_i,
    input  logic                   mul_req_i,
    input  logic [ROB_IDX_LEN-1:0] mul_tag_i,
    input  logic [XLEN-1:0]        mul_value_i,
    output logic                   alu_gnt_o,
    output logic                   mul_gnt_o,
    output logic                   cdb_valid_o,
    output logic [ROB_IDX_LEN-1:0] cdb_rob_idx_o,
    output logic [XLEN-1:0]        cdb_value_o,
    output logic                   cdb_except_o,
    output except_e                cdb_except_code_o
);

    logic mul_prio;     // High when the multiplier wins a tie

    assign alu_gnt_o = alu_req_i && (!mul_req_i || !mul_prio);
    assign mul_gnt_o = mul_req_i && (!alu_req_i || mul_prio);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mul_prio <= 1'b0;
        end else if (alu_gnt_o) begin
            mul_prio <= 1'b1;                   // Other side first next time
        end else if (mul_gnt_o) begin
            mul_prio <= 1'b0;
        end
    end

    // Multiplier never raises an exception
    assign cdb_valid_o       = alu_gnt_o || mul_gnt_o;
    assign cdb_rob_idx_o     = mul_gnt_o ? mul_tag_i : alu_tag_i;
    assign cdb_value_o       = mul_gnt_o ? mul_value_i : alu_value_i;
    assign cdb_except_o      = alu_gnt_o && alu_except_i;
    assign cdb_except_code_o = alu_gnt_o ? alu_except_code_i : EXC_NONE;

endmodule

`default_nettype wire

// File: verilog/core_cfg_pkg.sv
// Core configuration package
// Data path width and destination register index width
`default_nettype none

package core_cfg_pkg;

    localparam int XLEN        = 32;    // Integer data width
    localparam int REG_IDX_LEN = 5;     // Destination register index width

endpackage

`default_nettype wire

// File: verilog/dispatch_unit.sv
// Dispatch unit
// Decodes the opcode, allocates the ROB tail and routes to ALU or multiplier
`timescale 1ns/10ps
`default_nettype none

module dispatch_unit import core_cfg_pkg::*; import expipe_pkg::*; #(
    parameter  int ROB_DEPTH   = 8,
    localparam int ROB_IDX_LEN = $clog2(ROB_DEPTH)
) (
    input  logic                   issue_valid_i,
    output logic                   issue_ready_o,
    input  op_e                    issue_op_i,
    input  logic [REG_IDX_LEN-1:0] issue_rd_i,
    input  logic [XLEN-1:0]        issue_a_i,
    input  logic [XLEN-1:0]        issue_b_i,
    input  logic                   flush_i,
    // ROB allocation
    input  logic                   rob_ready_i,
    input  logic [ROB_IDX_LEN-1:0] rob_tail_idx_i,
    output logic                   rob_push_valid_o,
    output logic                   rob_res_ready_o,
    output logic                   rob_except_o,
    output except_e                rob_except_code_o,
    output logic [XLEN-1:0]        rob_value_o,
    output logic [REG_IDX_LEN-1:0] rob_rd_o,
    // Execution units
    input  logic                   alu_ready_i,
    input  logic                   mul_ready_i,
    output logic                   alu_valid_o,
    output op_e                    alu_op_o,
    output logic                   mul_valid_o,
    output logic [XLEN-1:0]        unit_a_o,
    output logic [XLEN-1:0]        unit_b_o,
    output logic [ROB_IDX_LEN-1:0] unit_tag_o
);

    logic to_alu, to_mul, early, illegal;
    logic unit_ok, fire;

    always_comb begin
        to_alu  = 1'b0;
        to_mul  = 1'b0;
        early   = 1'b0;
        illegal = 1'b0;
        unique case (issue_op_i)
            OP_ADD, OP_SUB, OP_XOR: to_alu = 1'b1;
            OP_MUL:                 to_mul = 1'b1;
            OP_LDI:                 early  = 1'b1;  // Operand a is the result
            default:                illegal = 1'b1; // OP_ILL and unused codes
        endcase
    end

    // LDI and ILL need only a free ROB entry
    assign unit_ok       = to_alu ? alu_ready_i : (to_mul ? mul_ready_i : 1'b1);
    assign issue_ready_o = rob_ready_i && unit_ok && !flush_i;
    assign fire          = issue_valid_i && issue_ready_o;

    assign rob_push_valid_o  = fire;
    assign rob_res_ready_o   = early;
    assign rob_except_o      = illegal;
    assign rob_except_code_o = illegal ? EXC_ILLEGAL : EXC_NONE;
    assign rob_value_o       = issue_a_i;       // LDI value or ILL aux data
    assign rob_rd_o          = issue_rd_i;

    assign alu_valid_o = fire && to_alu;
    assign alu_op_o    = issue_op_i;
    assign mul_valid_o = fire && to_mul;
    assign unit_a_o    = issue_a_i;
    assign unit_b_o    = issue_b_i;
    assign unit_tag_o  = rob_tail_idx_i;        // Tag is the allocated ROB entry

endmodule

`default_nettype wire

// File: verilog/expipe_pkg.sv
// Execution pipeline package
// Opcode and exception encodings, multiplier iteration count
`default_nettype none

package expipe_pkg;

    // Opcodes seen by dispatch
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,  // ALU
        OP_SUB = 3'd1,  // ALU
        OP_XOR = 3'd2,  // ALU
        OP_MUL = 3'd3,  // Iterative multiplier
        OP_LDI = 3'd4,  // Immediate load, resolved at issue
        OP_ILL = 3'd5   // Illegal, raises an exception at issue
    } op_e;

    // Exception codes carried into the ROB
    typedef enum logic [1:0] {
        EXC_NONE     = 2'd0,
        EXC_ILLEGAL  = 2'd1,
        EXC_OVERFLOW = 2'd2
    } except_e;

    // One multiplier bit per cycle
    localparam int MUL_ITERS = core_cfg_pkg::XLEN;

endpackage

`default_nettype wire

// File: verilog/modn_counter.sv
// Modulo-N counter
// Enable and synchronous clear, clear has priority
`timescale 1ns/10ps
`default_nettype none

module modn_counter #(
    parameter int N = 8
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 en_i,
    input  logic                 clr_i,
    output logic [$clog2(N)-1:0] count_o
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_o <= '0;
        end else if (clr_i) begin
            count_o <= '0;                              // Clear wins over enable
        end else if (en_i) begin
            if (count_o == $clog2(N)'(N - 1)) begin
                count_o <= '0;                          // Wrap at N-1
            end else begin
                count_o <= count_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/mul_unit.sv
// Iterative multiplier
// Shift-and-add, one bit per cycle, low XLEN bits held until CDB grant
`timescale 1ns/10ps
`default_nettype none

module mul_unit import core_cfg_pkg::*; import expipe_pkg::*; #(
    parameter  int ROB_DEPTH   = 8,
    localparam int ROB_IDX_LEN = $clog2(ROB_DEPTH)
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   valid_i,
    output logic                   ready_o,
    input  logic [XLEN-1:0]        a_i,
    input  logic [XLEN-1:0]        b_i,
    input  logic [ROB_IDX_LEN-1:0] tag_i,
    input  logic                   gnt_i,
    output logic                   req_o,
    output logic [ROB_IDX_LEN-1:0] tag_o,
    output logic [XLEN-1:0]        value_o
);

    localparam int CNT_W = $clog2(MUL_ITERS);

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_BUSY,    // Iterating
        MS_DONE     // Requesting the CDB
    } mul_state_e;

    mul_state_e      state;
    logic [CNT_W-1:0] cnt;
    logic [XLEN-1:0] acc, mcand, mplier;

    // Control path
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= MS_IDLE;
        end else if (flush_i) begin
            state <= MS_IDLE;
        end else begin
            case (state)
                MS_IDLE: if (valid_i) state <= MS_BUSY;
                MS_BUSY: if (cnt == CNT_W'(MUL_ITERS - 1)) state <= MS_DONE;
                MS_DONE: if (gnt_i) state <= MS_IDLE;
                default: state <= MS_IDLE;
            endcase
        end
    end

    // Data path, bit 0 is handled at acceptance
    always_ff @(posedge clk_i) begin
        if (state == MS_IDLE && valid_i) begin
            acc    <= b_i[0] ? a_i : '0;
            mcand  <= a_i << 1;
            mplier <= b_i >> 1;
            cnt    <= CNT_W'(1);
            tag_o  <= tag_i;
        end else if (state == MS_BUSY) begin
            if (mplier[0]) acc <= acc + mcand;      // Add shifted multiplicand
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            cnt    <= cnt + 1'b1;
        end
    end

    assign ready_o = (state == MS_IDLE);
    assign req_o   = (state == MS_DONE);
    assign value_o = acc;

endmodule

`default_nettype wire

// File: verilog/ooo_backend_top.sv
// Out-of-order back end top level
// Dispatch, ALU, multiplier, CDB arbiter and reorder buffer
`timescale 1ns/10ps
`default_nettype none

module ooo_backend_top import core_cfg_pkg::*; import expipe_pkg::*; #(
    parameter  int ROB_DEPTH   = 8,
    localparam int ROB_IDX_LEN = $clog2(ROB_DEPTH)
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   issue_valid_i,
    output logic                   issue_ready_o,
    input  op_e                    issue_op_i,
    input  logic [REG_IDX_LEN-1:0] issue_rd_i,
    input  logic [XLEN-1:0]        issue_a_i,
    input  logic [XLEN-1:0]        issue_b_i,
    output logic [ROB_IDX_LEN-1:0] issue_tag_o,
    input  logic                   comm_ready_i,
    output logic                   comm_valid_o,
    output logic [REG_IDX_LEN-1:0] comm_rd_o,
    output logic [XLEN-1:0]        comm_value_o,
    output logic                   comm_except_o,
    output except_e                comm_except_code_o,
    output logic [ROB_IDX_LEN-1:0] comm_tag_o
);

    // Dispatch to ROB
    logic                   rob_push_valid, rob_res_ready, rob_except, rob_ready;
    except_e                rob_except_code;
    logic [XLEN-1:0]        rob_value;
    logic [REG_IDX_LEN-1:0] rob_rd;
    logic [ROB_IDX_LEN-1:0] rob_tail_idx;
    // Dispatch to units
    logic                   alu_valid, alu_ready, mul_valid, mul_ready;
    op_e                    alu_op;
    logic [XLEN-1:0]        unit_a, unit_b;
    logic [ROB_IDX_LEN-1:0] unit_tag;
    // Units to arbiter
    logic                   alu_req, alu_gnt, alu_except, mul_req, mul_gnt;
    except_e                alu_except_code;
    logic [ROB_IDX_LEN-1:0] alu_tag, mul_tag;
    logic [XLEN-1:0]        alu_value, mul_value;
    // CDB
    logic                   cdb_valid, cdb_except;
    logic [ROB_IDX_LEN-1:0] cdb_rob_idx;
    logic [XLEN-1:0]        cdb_value;
    except_e                cdb_except_code;

    dispatch_unit #(.ROB_DEPTH(ROB_DEPTH)) u_dispatch (
        .issue_valid_i     (issue_valid_i),
        .issue_ready_o     (issue_ready_o),
        .issue_op_i        (issue_op_i),
        .issue_rd_i        (issue_rd_i),
        .issue_a_i         (issue_a_i),
        .issue_b_i         (issue_b_i),
        .flush_i           (flush_i),
        .rob_ready_i       (rob_ready),
        .rob_tail_idx_i    (rob_tail_idx),
        .rob_push_valid_o  (rob_push_valid),
        .rob_res_ready_o   (rob_res_ready),
        .rob_except_o      (rob_except),
        .rob_except_code_o (rob_except_code),
        .rob_value_o       (rob_value),
        .rob_rd_o          (rob_rd),
        .alu_ready_i       (alu_ready),
        .mul_ready_i       (mul_ready),
        .alu_valid_o       (alu_valid),
        .alu_op_o          (alu_op),
        .mul_valid_o       (mul_valid),
        .unit_a_o          (unit_a),
        .unit_b_o          (unit_b),
        .unit_tag_o        (unit_tag)
    );

    alu_unit #(.ROB_DEPTH(ROB_DEPTH)) u_alu (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .valid_i       (alu_valid),
        .ready_o       (alu_ready),
        .op_i          (alu_op),
        .a_i           (unit_a),
        .b_i           (unit_b),
        .tag_i         (unit_tag),
        .gnt_i         (alu_gnt),
        .req_o         (alu_req),
        .tag_o         (alu_tag),
        .value_o       (alu_value),
        .except_o      (alu_except),
        .except_code_o (alu_except_code)
    );

    mul_unit #(.ROB_DEPTH(ROB_DEPTH)) u_mul (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (mul_valid),
        .ready_o (mul_ready),
        .a_i     (unit_a),
        .b_i     (unit_b),
        .tag_i   (unit_tag),
        .gnt_i   (mul_gnt),
        .req_o   (mul_req),
        .tag_o   (mul_tag),
        .value_o (mul_value)
    );

    cdb_arbiter #(.ROB_DEPTH(ROB_DEPTH)) u_arb (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .alu_req_i         (alu_req),
        .alu_tag_i         (alu_tag),
        .alu_value_i       (alu_value),
        .alu_except_i      (alu_except),
        .alu_except_code_i (alu_except_code),
        .mul_req_i         (mul_req),
        .mul_tag_i         (mul_tag),
        .mul_value_i       (mul_value),
        .alu_gnt_o         (alu_gnt),
        .mul_gnt_o         (mul_gnt),
        .cdb_valid_o       (cdb_valid),
        .cdb_rob_idx_o     (cdb_rob_idx),
        .cdb_value_o       (cdb_value),
        .cdb_except_o      (cdb_except),
        .cdb_except_code_o (cdb_except_code)
    );

    rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .flush_i            (flush_i),
        .push_valid_i       (rob_push_valid),
        .push_ready_o       (rob_ready),
        .push_res_ready_i   (rob_res_ready),
        .push_except_i      (rob_except),
        .push_except_code_i (rob_except_code),
        .push_value_i       (rob_value),
        .push_rd_i          (rob_rd),
        .tail_idx_o         (rob_tail_idx),
        .cdb_valid_i        (cdb_valid),
        .cdb_rob_idx_i      (cdb_rob_idx),
        .cdb_value_i        (cdb_value),
        .cdb_except_i       (cdb_except),
        .cdb_except_code_i  (cdb_except_code),
        .comm_ready_i       (comm_ready_i),
        .comm_valid_o       (comm_valid_o),
        .comm_rd_o          (comm_rd_o),
        .comm_value_o       (comm_value_o),
        .comm_except_o      (comm_except_o),
        .comm_except_code_o (comm_except_code_o),
        .head_idx_o         (comm_tag_o)
    );

    assign issue_tag_o = rob_tail_idx;      // Tag of the instruction being issued

endmodule

`default_nettype wire

// File: verilog/rob.sv
// Reorder buffer
// Issue write port, CDB write port, in-order commit port
`timescale 1ns/10ps
`default_nettype none

module rob import core_cfg_pkg::*; import expipe_pkg::*; #(
    parameter  int ROB_DEPTH   = 8,
    localparam int ROB_IDX_LEN = $clog2(ROB_DEPTH)
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    // Issue side
    input  logic                   push_valid_i,
    output logic                   push_ready_o,
    input  logic                   push_res_ready_i,    // Result known at issue
    input  logic                   push_except_i,
    input  except_e                push_except_code_i,
    input  logic [XLEN-1:0]        push_value_i,        // Result or exception aux data
    input  logic [REG_IDX_LEN-1:0] push_rd_i,
    output logic [ROB_IDX_LEN-1:0] tail_idx_o,
    // CDB side, always accepted
    input  logic                   cdb_valid_i,
    input  logic [ROB_IDX_LEN-1:0] cdb_rob_idx_i,
    input  logic [XLEN-1:0]        cdb_value_i,
    input  logic                   cdb_except_i,
    input  except_e                cdb_except_code_i,
    // Commit side
    input  logic                   comm_ready_i,
    output logic                   comm_valid_o,
    output logic [REG_IDX_LEN-1:0] comm_rd_o,
    output logic [XLEN-1:0]        comm_value_o,
    output logic                   comm_except_o,
    output except_e                comm_except_code_o,
    output logic [ROB_IDX_LEN-1:0] head_idx_o
);

    logic [ROB_IDX_LEN-1:0] head_idx, tail_idx;
    logic                   push, pop;

    // Entry status bits
    logic                   ent_valid     [ROB_DEPTH];
    logic                   ent_res_ready [ROB_DEPTH];
    logic                   ent_except    [ROB_DEPTH];
    // Entry payload
    logic [REG_IDX_LEN-1:0] ent_rd        [ROB_DEPTH];
    logic [XLEN-1:0]        ent_value     [ROB_DEPTH];
    except_e                ent_code      [ROB_DEPTH];

    assign push_ready_o = !ent_valid[tail_idx];                 // Tail entry free
    assign push         = push_valid_i && push_ready_o && !flush_i;
    assign comm_valid_o = ent_valid[head_idx] && ent_res_ready[head_idx] && !flush_i;
    assign pop          = comm_valid_o && comm_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                ent_valid[i]     <= 1'b0;
                ent_res_ready[i] <= 1'b0;
                ent_except[i]    <= 1'b0;
            end
        end else if (flush_i) begin
            // Drop everything in flight
            for (int i = 0; i < ROB_DEPTH; i++) begin
                ent_valid[i]     <= 1'b0;
                ent_res_ready[i] <= 1'b0;
                ent_except[i]    <= 1'b0;
            end
        end else begin
            if (push) begin
                ent_valid[tail_idx]     <= 1'b1;
                ent_res_ready[tail_idx] <= push_res_ready_i || push_except_i;
                ent_except[tail_idx]    <= push_except_i;
            end
            if (cdb_valid_i) begin                              // Out-of-order result
                ent_res_ready[cdb_rob_idx_i] <= 1'b1;
                ent_except[cdb_rob_idx_i]    <= cdb_except_i;
            end
            if (pop) ent_valid[head_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            ent_rd[tail_idx]    <= push_rd_i;
            ent_value[tail_idx] <= push_value_i;                // Aux data for early entries
            ent_code[tail_idx]  <= push_except_code_i;
        end
        if (cdb_valid_i) begin
            ent_value[cdb_rob_idx_i] <= cdb_value_i;
            ent_code[cdb_rob_idx_i]  <= cdb_except_code_i;
        end
    end

    modn_counter #(.N(ROB_DEPTH)) u_head_cnt (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (pop),
        .clr_i   (flush_i),
        .count_o (head_idx)
    );

    modn_counter #(.N(ROB_DEPTH)) u_tail_cnt (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (push),
        .clr_i   (flush_i),
        .count_o (tail_idx)
    );

    assign tail_idx_o         = tail_idx;
    assign head_idx_o         = head_idx;
    assign comm_rd_o          = ent_rd[head_idx];
    assign comm_value_o       = ent_value[head_idx];
    assign comm_except_o      = ent_except[head_idx];
    assign comm_except_code_o = ent_code[head_idx];

endmodule

`default_nettype wire
